// File: common/cpu_pkg.sv
package cpu_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       data_t;
  typedef logic [XLEN-1:0]       addr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ADDI x0, x0, 0
  localparam data_t NOP_INSTR = 32'h0000_0013;

  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_STORE  = 7'b0100011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  typedef struct packed {
    addr_t pc;
    data_t instr;
  } if_id_t;

  typedef struct packed {
    alu_op_t   op;
    data_t     a;
    data_t     b;
    data_t     sdata;
    reg_addr_t rd;
    logic      we;
    logic      store;
  } id_ex_t;

  typedef struct packed {
    reg_addr_t rd;
    logic      we;
    data_t     result;
  } ex_wb_t;

  // Reset fill of the IF/ID stage
  localparam if_id_t IF_ID_NOP = '{pc: '0, instr: NOP_INSTR};

endpackage

// File: common/rf_read_if.sv
interface rf_read_if;
  import cpu_pkg::*;

  reg_addr_t raddr1;
  reg_addr_t raddr2;
  data_t     rdata1;
  data_t     rdata2;

  modport decoder (
    output raddr1,
    output raddr2,
    input  rdata1,
    input  rdata2
  );

  modport regfile (
    input  raddr1,
    input  raddr2,
    output rdata1,
    output rdata2
  );

endinterface

// File: hw/pipe_reg.sv
module pipe_reg #(
  parameter type T         = logic,
  parameter T    RESET_VAL = '0
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic valid_i,
  input  T     data_i,
  output logic valid_o,
  output T     data_o
);

  // Stages never stall, so the register loads every cycle
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
      data_o  <= RESET_VAL;
    end else begin
      valid_o <= valid_i;
      data_o  <= data_i;
    end
  end

endmodule

// File: hw/regfile.sv
module regfile (
  input  logic               clk,
  input  logic               rst_n_i,
  rf_read_if.regfile         rf,
  input  logic               we_i,
  input  cpu_pkg::reg_addr_t waddr_i,
  input  cpu_pkg::data_t     wdata_i
);
  import cpu_pkg::*;

  // x0 has no storage
  data_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst_n_i && we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  always_comb begin
    rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];
  end

  // Written data reads back one cycle later and x0 stays zero
  a_write_read: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    we_i |=>
      ((rf.raddr1 != $past(waddr_i)) ||
       (rf.rdata1 == (($past(waddr_i) == '0) ? '0 : $past(wdata_i)))) &&
      ((rf.raddr2 != $past(waddr_i)) ||
       (rf.rdata2 == (($past(waddr_i) == '0) ? '0 : $past(wdata_i))))
  ) else $error("regfile: read after write returned stale data");

endmodule

// File: core/fetch.sv
module fetch (
  input  logic           clk,
  input  logic           rst_n_i,
  output cpu_pkg::addr_t pc_o
);
  import cpu_pkg::*;

  addr_t pc;

  // No branches, so the PC only steps forward
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc <= '0;
    end else begin
      pc <= pc + addr_t'(4);
    end
  end

  assign pc_o = pc;

endmodule

// File: core/decode.sv
module decode (
  input  cpu_pkg::if_id_t id_i,
  input  logic            id_valid_i,
  rf_read_if.decoder      rf,
  input  cpu_pkg::ex_wb_t ex_fwd_i,
  input  logic            ex_fwd_valid_i,
  input  cpu_pkg::ex_wb_t wb_fwd_i,
  input  logic            wb_fwd_valid_i,
  output cpu_pkg::id_ex_t ex_o
);
  import cpu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  data_t      imm_i;
  data_t      imm_s;
  data_t      imm_u;
  data_t      rs1_val;
  data_t      rs2_val;
  alu_op_t    func_op;

  assign opcode = id_i.instr[6:0];
  assign rd     = id_i.instr[11:7];
  assign funct3 = id_i.instr[14:12];
  assign rs1    = id_i.instr[19:15];
  assign rs2    = id_i.instr[24:20];
  assign funct7 = id_i.instr[31:25];

  assign imm_i = {{20{id_i.instr[31]}}, id_i.instr[31:20]};
  assign imm_s = {{20{id_i.instr[31]}}, id_i.instr[31:25], id_i.instr[11:7]};
  assign imm_u = {id_i.instr[31:12], 12'b0};

  assign rf.raddr1 = rs1;
  assign rf.raddr2 = rs2;

  // EX result is younger, so it wins over WB
  function automatic data_t forward(reg_addr_t idx, data_t rf_val);
    if (idx == '0) begin
      return rf_val;
    end
    if (ex_fwd_valid_i && ex_fwd_i.we && (ex_fwd_i.rd == idx)) begin
      return ex_fwd_i.result;
    end
    if (wb_fwd_valid_i && wb_fwd_i.we && (wb_fwd_i.rd == idx)) begin
      return wb_fwd_i.result;
    end
    return rf_val;
  endfunction

  always_comb begin
    rs1_val = forward(rs1, rf.rdata1);
    rs2_val = forward(rs2, rf.rdata2);
  end

  // Shared by OP and OP-IMM but SUB only exists in OP
  always_comb begin
    case (funct3)
      3'b000:  func_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  func_op = ALU_SLL;
      3'b010:  func_op = ALU_SLT;
      3'b011:  func_op = ALU_SLTU;
      3'b100:  func_op = ALU_XOR;
      3'b101:  func_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  func_op = ALU_OR;
      default: func_op = ALU_AND;
    endcase
  end

  always_comb begin
    ex_o.op    = func_op;
    ex_o.a     = rs1_val;
    ex_o.b     = rs2_val;
    ex_o.sdata = rs2_val;
    ex_o.rd    = rd;
    ex_o.we    = 1'b0;
    ex_o.store = 1'b0;
    case (opcode)
      OPC_OP: begin
        ex_o.we = (funct7 == 7'b0000000) ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OPC_OP_IMM: begin
        ex_o.b = imm_i;
        if (funct3 == 3'b001) begin
          ex_o.we = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          ex_o.we = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          ex_o.we = 1'b1;
        end
      end
      OPC_LUI: begin
        ex_o.op = ALU_PASS_B;
        ex_o.b  = imm_u;
        ex_o.we = 1'b1;
      end
      OPC_STORE: begin
        // Address is base plus offset through the adder
        ex_o.op    = ALU_ADD;
        ex_o.b     = imm_s;
        ex_o.store = (funct3 == 3'b010);
      end
      default: begin
      end
    endcase
    ex_o.we    = ex_o.we & id_valid_i;
    ex_o.store = ex_o.store & id_valid_i;
  end

endmodule

// File: core/execute.sv
module execute (
  input  cpu_pkg::id_ex_t ex_i,
  input  logic            ex_valid_i,
  output cpu_pkg::ex_wb_t wb_o,
  output logic            dmem_we_o,
  output cpu_pkg::addr_t  dmem_addr_o,
  output cpu_pkg::data_t  dmem_wdata_o
);
  import cpu_pkg::*;

  logic [4:0] shamt;
  data_t      result;

  assign shamt = ex_i.b[4:0];

  always_comb begin
    case (ex_i.op)
      ALU_ADD:    result = ex_i.a + ex_i.b;
      ALU_SUB:    result = ex_i.a - ex_i.b;
      ALU_SLL:    result = ex_i.a << shamt;
      ALU_SLT:    result = data_t'($signed(ex_i.a) < $signed(ex_i.b));
      ALU_SLTU:   result = data_t'(ex_i.a < ex_i.b);
      ALU_XOR:    result = ex_i.a ^ ex_i.b;
      ALU_SRL:    result = ex_i.a >> shamt;
      ALU_SRA:    result = data_t'($signed(ex_i.a) >>> shamt);
      ALU_OR:     result = ex_i.a | ex_i.b;
      ALU_AND:    result = ex_i.a & ex_i.b;
      ALU_PASS_B: result = ex_i.b;
      default:    result = '0;
    endcase
  end

  assign wb_o.rd     = ex_i.rd;
  assign wb_o.we     = ex_valid_i & ex_i.we;
  assign wb_o.result = result;

  // Store pulse lasts exactly the one cycle the instruction sits here
  assign dmem_we_o    = ex_valid_i & ex_i.store;
  assign dmem_addr_o  = result;
  assign dmem_wdata_o = ex_i.sdata;

  always_comb begin
    if (dmem_we_o) begin
      a_store_aligned: assert (result[1:0] == 2'b00)
        else $error("execute: misaligned store address %h", result);
    end
  end

endmodule

// File: core/core_top.sv
module core_top (
  input  logic           clk,
  input  logic           rst_n_i,
  input  cpu_pkg::data_t imem_rdata_i,
  output cpu_pkg::addr_t imem_addr_o,
  output logic           dmem_we_o,
  output cpu_pkg::addr_t dmem_addr_o,
  output cpu_pkg::data_t dmem_wdata_o
);
  import cpu_pkg::*;

  addr_t  if_pc;
  if_id_t if_data;
  if_id_t id_data;
  logic   id_valid;
  id_ex_t id_out;
  id_ex_t ex_data;
  logic   ex_valid;
  ex_wb_t ex_out;
  ex_wb_t wb_data;
  logic   wb_valid;

  rf_read_if rf_bus ();

  assign imem_addr_o = if_pc;
  assign if_data     = '{pc: if_pc, instr: imem_rdata_i};

  // IF
  fetch fetch0 (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .pc_o   (if_pc)
  );

  // IF-ID
  pipe_reg #(
    .T        (if_id_t),
    .RESET_VAL(IF_ID_NOP)
  ) if_id0 (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .valid_i(1'b1),
    .data_i (if_data),
    .valid_o(id_valid),
    .data_o (id_data)
  );

  // ID
  decode decode0 (
    .id_i          (id_data),
    .id_valid_i    (id_valid),
    .rf            (rf_bus.decoder),
    .ex_fwd_i      (ex_out),
    .ex_fwd_valid_i(ex_valid),
    .wb_fwd_i      (wb_data),
    .wb_fwd_valid_i(wb_valid),
    .ex_o          (id_out)
  );

  // ID-EX
  pipe_reg #(
    .T(id_ex_t)
  ) id_ex0 (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .valid_i(id_valid),
    .data_i (id_out),
    .valid_o(ex_valid),
    .data_o (ex_data)
  );

  // EX
  execute execute0 (
    .ex_i        (ex_data),
    .ex_valid_i  (ex_valid),
    .wb_o        (ex_out),
    .dmem_we_o   (dmem_we_o),
    .dmem_addr_o (dmem_addr_o),
    .dmem_wdata_o(dmem_wdata_o)
  );

  // EX-WB
  pipe_reg #(
    .T(ex_wb_t)
  ) ex_wb0 (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .valid_i(ex_valid),
    .data_i (ex_out),
    .valid_o(wb_valid),
    .data_o (wb_data)
  );

  // WB
  regfile regfile0 (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .rf     (rf_bus.regfile),
    .we_i   (wb_data.we),
    .waddr_i(wb_data.rd),
    .wdata_i(wb_data.result)
  );

endmodule

// File: sim/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Architectural state and expected store list
data_t model_regs [32];
addr_t exp_addr_q [$];
data_t exp_data_q [$];

function automatic void model_reset();
  int i;
  for (i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  exp_addr_q.delete();
  exp_data_q.delete();
endfunction

// RV32I integer function, alt selects SUB or SRA
function automatic data_t model_alu(logic [2:0] f3, logic alt, data_t x, data_t y);
  logic [4:0] sh;
  sh = y[4:0];
  case (f3)
    3'b000:  return alt ? x - y : x + y;
    3'b001:  return x << sh;
    3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    3'b011:  return (x < y) ? 32'd1 : 32'd0;
    3'b100:  return x ^ y;
    3'b101:  return alt ? data_t'($signed(x) >>> sh) : x >> sh;
    3'b110:  return x | y;
    default: return x & y;
  endcase
endfunction

function automatic void model_exec(data_t instr);
  logic [6:0] opc;
  logic [2:0] f3;
  logic [6:0] f7;
  reg_addr_t  rd;
  data_t      a;
  data_t      b;
  data_t      imm_i;
  data_t      imm_s;
  data_t      val;
  logic       wr;

  opc   = instr[6:0];
  rd    = instr[11:7];
  f3    = instr[14:12];
  f7    = instr[31:25];
  a     = model_regs[instr[19:15]];
  b     = model_regs[instr[24:20]];
  imm_i = {{20{instr[31]}}, instr[31:20]};
  imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  wr    = 1'b0;
  val   = '0;
  case (opc)
    // LUI
    7'b0110111: begin
      wr  = 1'b1;
      val = {instr[31:12], 12'h000};
    end
    // OP-IMM, shift encodings carry funct7 in the immediate
    7'b0010011: begin
      if (f3 == 3'b001) begin
        wr = (f7 == 7'h00);
      end else if (f3 == 3'b101) begin
        wr = (f7 == 7'h00) || (f7 == 7'h20);
      end else begin
        wr = 1'b1;
      end
      val = model_alu(f3, (f3 == 3'b101) && f7[5], a, imm_i);
    end
    // OP
    7'b0110011: begin
      wr  = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101));
      val = model_alu(f3, f7[5], a, b);
    end
    // Only SW among the stores
    7'b0100011: begin
      if (f3 == 3'b010) begin
        exp_addr_q.push_back(a + imm_s);
        exp_data_q.push_back(b);
      end
    end
    default: begin
    end
  endcase
  if (wr && rd != 5'd0) begin
    model_regs[rd] = val;
  end
endfunction

`endif

// File: sim/tb_core.sv
module tb_core;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int IMEM_AW      = 8;
  localparam int IMEM_WORDS   = 1 << IMEM_AW;
  localparam int RESET_CYCLES = 10;
  localparam int DRAIN_CYCLES = 4;
  localparam int SEED_WORDS   = 62;
  localparam int DUMP_WORDS   = 31;
  localparam int FETCH_BODY   = 12;
  localparam int IMM_BODY     = 40;
  localparam int REG_BODY     = 60;
  localparam int FWD_BODY     = 80;
  localparam int X0_BODY      = 40;
  localparam int STORE_GROUPS = 30;
  localparam int NUM_TESTS    = 6;
  localparam int TOTAL_WORDS  = FETCH_BODY + 5 * (SEED_WORDS + DUMP_WORDS) + IMM_BODY +
                                REG_BODY + FWD_BODY + X0_BODY + 3 * STORE_GROUPS;
  localparam int WATCHDOG_NS  = (TOTAL_WORDS + 20 * NUM_TESTS) * 100;
  localparam int DUMP_BASE    = 1024;
  localparam int FWD_BASE     = 256;
  localparam int X0_BASE      = 512;

  logic  clk;
  logic  rst_n_i;
  data_t imem_rdata_i;
  addr_t imem_addr_o;
  logic  dmem_we_o;
  addr_t dmem_addr_o;
  data_t dmem_wdata_o;

  data_t  imem [IMEM_WORDS];
  data_t  prog [$];
  integer seed = 32'hd6b30a45;
  int     err_count;
  int     check_count;
  int     failed_tests;

  `include "core_model.svh"

  core_top DUT (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .imem_rdata_i(imem_rdata_i),
    .imem_addr_o (imem_addr_o),
    .dmem_we_o   (dmem_we_o),
    .dmem_addr_o (dmem_addr_o),
    .dmem_wdata_o(dmem_wdata_o)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Combinational instruction memory with NOP past the array
  always_comb begin
    if (imem_addr_o < addr_t'(IMEM_WORDS * 4)) begin
      imem_rdata_i = imem[imem_addr_o[IMEM_AW+1:2]];
    end else begin
      imem_rdata_i = NOP_INSTR;
    end
  end

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    check_count++;
    if (act !== exp) begin
      $display("[FAIL] %0d ns %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_word(input string name, input data_t exp, input data_t act);
    check_count++;
    if (act !== exp) begin
      $display("[FAIL] %0d ns %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      $display("[FAIL] %0d ns %s expected %b got %b", $time, name, exp, act);
      err_count++;
    end
  endtask

  function automatic data_t rand_word();
    return $random(seed);
  endfunction

  function automatic reg_addr_t rand_reg(int lo, int hi);
    data_t w;
    w = $random(seed);
    return reg_addr_t'(lo + int'(w % data_t'(hi - lo + 1)));
  endfunction

  function automatic int rand_below(int n);
    data_t w;
    w = $random(seed);
    return int'(w % data_t'(n));
  endfunction

  function automatic data_t encode_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic data_t encode_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic data_t encode_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic data_t encode_u(logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // Legal OP-IMM word where shift immediates get a valid funct7
  function automatic data_t rand_op_imm(reg_addr_t rd, reg_addr_t rs1);
    data_t       w;
    logic [11:0] imm;
    w   = rand_word();
    imm = w[31:20];
    if (w[14:12] == 3'b001) begin
      imm[11:5] = 7'h00;
    end else if (w[14:12] == 3'b101) begin
      imm[11:5] = w[30] ? 7'h20 : 7'h00;
    end
    return encode_i(imm, rs1, w[14:12], rd);
  endfunction

  function automatic data_t rand_op_reg(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    data_t      w;
    logic [6:0] f7;
    w  = rand_word();
    f7 = 7'h00;
    if ((w[14:12] == 3'b000 || w[14:12] == 3'b101) && w[30]) begin
      f7 = 7'h20;
    end
    return encode_r(f7, rs2, rs1, w[14:12], rd);
  endfunction

  task automatic add_seeds();
    data_t w;
    int    r;
    for (r = 1; r < 32; r++) begin
      w = rand_word();
      prog.push_back(encode_u(w[31:12], reg_addr_t'(r)));
      prog.push_back(encode_i(w[11:0], reg_addr_t'(r), 3'b000, reg_addr_t'(r)));
    end
  endtask

  task automatic add_dump();
    int r;
    for (r = 1; r < 32; r++) begin
      prog.push_back(encode_s(12'(DUMP_BASE + 4 * (r - 1)), reg_addr_t'(r), 5'd0));
    end
  endtask

  task automatic add_fwd_body();
    int i;
    for (i = 0; i < FWD_BODY; i++) begin
      case (rand_below(5))
        0: prog.push_back(encode_s(12'(FWD_BASE + 4 * rand_below(8)), rand_reg(1, 4), 5'd0));
        1: prog.push_back(rand_op_imm(rand_reg(1, 4), rand_reg(1, 4)));
        default: prog.push_back(rand_op_reg(rand_reg(1, 4), rand_reg(1, 4), rand_reg(1, 4)));
      endcase
    end
  endtask

  task automatic add_x0_body();
    data_t w;
    int    i;
    for (i = 0; i < X0_BODY; i++) begin
      w = rand_word();
      case (rand_below(5))
        0: prog.push_back(rand_op_imm(5'd0, rand_reg(1, 31)));
        1: prog.push_back(rand_op_reg(5'd0, rand_reg(1, 31), rand_reg(1, 31)));
        2: begin
          if (w[6:0] inside {7'h13, 7'h33, 7'h37, 7'h23}) begin
            w[6] = ~w[6];
          end
          prog.push_back(w);
        end
        3: prog.push_back(encode_s(12'(X0_BASE + 4 * rand_below(16)), 5'd0, 5'd0));
        // M-extension funct7 is not part of the core
        default: prog.push_back(encode_r(7'h01, rand_reg(1, 31), rand_reg(1, 31), w[14:12],
                                         rand_reg(1, 31)));
      endcase
    end
  endtask

  task automatic add_store_body();
    data_t     w;
    reg_addr_t rb;
    int        i;
    for (i = 0; i < STORE_GROUPS; i++) begin
      w  = rand_word();
      rb = rand_reg(1, 31);
      prog.push_back(encode_u(20'(rand_word() >> 12), rb));
      prog.push_back(encode_i({w[11:2], 2'b00}, rb, 3'b000, rb));
      prog.push_back(encode_s({w[23:14], 2'b00}, rand_reg(1, 31), rb));
    end
  endtask

  task automatic run_test(input string name);
    int    c;
    int    i;
    int    n_st;
    int    errs_before;
    addr_t exp_pc;

    errs_before = err_count;
    model_reset();
    for (i = 0; i < prog.size(); i++) begin
      model_exec(prog[i]);
    end

    @(posedge clk);
    #1;
    rst_n_i = 1'b0;
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : NOP_INSTR;
    end
    for (c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clk);
      // PC and pipeline clear at the first edge in reset
      if (c > 0) begin
        check_addr("imem_addr_o", '0, imem_addr_o);
        check_bit("dmem_we_o", 1'b0, dmem_we_o);
      end
    end
    @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    // First cycle out of reset still fetches word 0
    exp_pc = '0;
    n_st   = 0;
    for (c = 0; c < prog.size() + DRAIN_CYCLES; c++) begin
      @(negedge clk);
      check_addr("imem_addr_o", exp_pc, imem_addr_o);
      exp_pc = exp_pc + 4;
      if (dmem_we_o === 1'b1) begin
        if (n_st < exp_addr_q.size()) begin
          check_addr("dmem_addr_o", exp_addr_q[n_st], dmem_addr_o);
          check_word("dmem_wdata_o", exp_data_q[n_st], dmem_wdata_o);
        end
        n_st++;
      end
    end
    if (n_st != exp_addr_q.size()) begin
      $display("test %s: the model expects %0d stores but the DUT made %0d",
               name, exp_addr_q.size(), n_st);
      err_count++;
    end

    if (err_count != errs_before) begin
      failed_tests++;
    end
    $display("test %s: %s, stores %0d, errors %0d", name,
             (err_count == errs_before) ? "passed" : "failed", n_st, err_count - errs_before);
  endtask

  initial begin
    rst_n_i      = 1'b0;
    err_count    = 0;
    check_count  = 0;
    failed_tests = 0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = NOP_INSTR;
    end

    prog.delete();
    for (int i = 0; i < FETCH_BODY; i++) begin
      prog.push_back(NOP_INSTR);
    end
    run_test("reset_fetch");

    prog.delete();
    add_seeds();
    for (int i = 0; i < IMM_BODY; i++) begin
      prog.push_back(rand_op_imm(rand_reg(1, 31), rand_reg(1, 31)));
    end
    add_dump();
    run_test("op_imm");

    prog.delete();
    add_seeds();
    for (int i = 0; i < REG_BODY; i++) begin
      prog.push_back(rand_op_reg(rand_reg(1, 31), rand_reg(1, 31), rand_reg(1, 31)));
    end
    add_dump();
    run_test("op_reg");

    prog.delete();
    add_seeds();
    add_fwd_body();
    add_dump();
    run_test("forwarding");

    prog.delete();
    add_seeds();
    add_x0_body();
    add_dump();
    run_test("x0_illegal");

    prog.delete();
    add_seeds();
    add_store_body();
    add_dump();
    run_test("store_addr");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             NUM_TESTS, failed_tests, check_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not complete within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: src.f
+incdir+sim
common/cpu_pkg.sv
common/rf_read_if.sv
hw/pipe_reg.sv
hw/regfile.sv
core/fetch.sv
core/decode.sv
core/execute.sv
core/core_top.sv
sim/tb_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module tb_core -Mdir obj_dir; then
  echo "run_sim: build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_core)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "run_sim: simulator exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "run_sim: pass line not found"
exit 1
